// ==== lsq_pkg.sv ====
// Shared widths, depths, word types and the load/store encoding, referenced by scoped name.
`default_nettype none

package lsq_pkg;

    // data and address width.
    localparam int XLEN = 32;

    // reorder-buffer tag width. Tag zero means the value is present.
    localparam int TAG_W = 5;

    // number of load/store buffer entries and the width of its pointers.
    localparam int LSQ_DEPTH = 8;
    localparam int LSQ_IDX_W = 3;

    // word-address width of the data memory.
    // The effective address picks a word through its bits MEM_AW+1 down to 2.
    localparam int MEM_AW = 8;
    localparam int MEM_WORDS = 1 << MEM_AW;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic {
        LDST_LW = 1'b0,
        LDST_SW = 1'b1
    } ldst_op_e;

endpackage

`default_nettype wire

// ==== ldst_buffer.sv ====
// Load/store entry queue: takes dispatch, snoops both bus channels and issues the head in order.
`timescale 1ns/1ps
`default_nettype none

module ldst_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     disp_valid,
    input  lsq_pkg::ldst_op_e        disp_op,
    input  lsq_pkg::tag_t            disp_rob_tag,
    input  lsq_pkg::tag_t            disp_rd,
    input  lsq_pkg::tag_t            disp_src1_tag,
    input  lsq_pkg::tag_t            disp_src2_tag,
    input  lsq_pkg::word_t           disp_src1_val,
    input  lsq_pkg::word_t           disp_src2_val,
    input  lsq_pkg::word_t           disp_imm,
    input  lsq_pkg::tag_t            cdb_ext_tag,
    input  lsq_pkg::tag_t            cdb_mem_tag,
    input  lsq_pkg::word_t           cdb_ext_val,
    input  lsq_pkg::word_t           cdb_mem_val,
    input  lsq_pkg::tag_t            rob_head,
    input  logic                     flush,
    input  logic                     mem_ack,
    output logic                     disp_ready,
    output logic                     mem_req,
    output lsq_pkg::ldst_op_e        mem_op,
    output lsq_pkg::word_t           mem_addr,
    output lsq_pkg::word_t           mem_data,
    output lsq_pkg::tag_t            mem_tag,
    output lsq_pkg::tag_t            mem_rd
);

    logic [lsq_pkg::LSQ_DEPTH-1:0] busy;
    logic [lsq_pkg::LSQ_IDX_W-1:0] head;
    logic [lsq_pkg::LSQ_IDX_W-1:0] tail;
    logic [lsq_pkg::LSQ_IDX_W:0]   count;

    lsq_pkg::ldst_op_e op_q     [lsq_pkg::LSQ_DEPTH];
    lsq_pkg::tag_t     rob_q    [lsq_pkg::LSQ_DEPTH];
    lsq_pkg::tag_t     rd_q     [lsq_pkg::LSQ_DEPTH];
    lsq_pkg::tag_t     tag1_q   [lsq_pkg::LSQ_DEPTH];
    lsq_pkg::tag_t     tag2_q   [lsq_pkg::LSQ_DEPTH];
    lsq_pkg::word_t    val2_q   [lsq_pkg::LSQ_DEPTH];
    lsq_pkg::word_t    imm_q    [lsq_pkg::LSQ_DEPTH];
    lsq_pkg::word_t    addr_q   [lsq_pkg::LSQ_DEPTH];

    // dispatch operands after a same-edge broadcast has been folded in.
    lsq_pkg::tag_t  d_tag1;
    lsq_pkg::tag_t  d_tag2;
    lsq_pkg::word_t d_val1;
    lsq_pkg::word_t d_val2;

    logic disp_fire;
    logic head_ready;
    logic store_blocked;
    logic issue_ok;
    logic release_fire;

    function automatic logic bus_hit(lsq_pkg::tag_t want, lsq_pkg::tag_t bus);
        return (want != '0) && (want == bus);
    endfunction

    assign disp_ready = (count != (lsq_pkg::LSQ_IDX_W+1)'(lsq_pkg::LSQ_DEPTH));
    assign disp_fire  = disp_valid && disp_ready && !flush;

    // a store may only touch memory once it is the oldest instruction in the ROB.
    assign store_blocked = (op_q[head] == lsq_pkg::LDST_SW) && (rob_q[head] != rob_head);
    assign head_ready    = busy[head] && (tag1_q[head] == '0) && (tag2_q[head] == '0);
    assign issue_ok      = !flush && !mem_req && !mem_ack && head_ready && !store_blocked;
    assign release_fire  = mem_req && mem_ack; // phase 3 of the handshake.

    always_comb begin
        d_tag1 = disp_src1_tag;
        d_val1 = disp_src1_val;
        d_tag2 = disp_src2_tag;
        d_val2 = disp_src2_val;
        if (bus_hit(disp_src1_tag, cdb_ext_tag)) begin
            d_tag1 = '0;
            d_val1 = cdb_ext_val;
        end else if (bus_hit(disp_src1_tag, cdb_mem_tag)) begin
            d_tag1 = '0;
            d_val1 = cdb_mem_val;
        end
        if (bus_hit(disp_src2_tag, cdb_ext_tag)) begin
            d_tag2 = '0;
            d_val2 = cdb_ext_val;
        end else if (bus_hit(disp_src2_tag, cdb_mem_tag)) begin
            d_tag2 = '0;
            d_val2 = cdb_mem_val;
        end
    end

    // occupancy, pointers and the request line.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            mem_req <= 1'b0;
        end else begin
            if (flush) begin
                busy  <= '0;
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                if (disp_fire) begin
                    busy[tail] <= 1'b1;
                    tail       <= tail + 1'b1;
                end
                if (release_fire) begin
                    busy[head] <= 1'b0;
                    head       <= head + 1'b1;
                end
                if (disp_fire && !release_fire) begin
                    count <= count + 1'b1;
                end else if (!disp_fire && release_fire) begin
                    count <= count - 1'b1;
                end
            end
            if (release_fire) begin
                mem_req <= 1'b0;
            end else if (issue_ok) begin
                mem_req <= 1'b1;
            end
        end
    end

    // entry payload, bus capture and the request payload.
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsq_pkg::LSQ_DEPTH; i++) begin
            if (busy[i]) begin
                // the base arriving also settles the effective address.
                if (bus_hit(tag1_q[i], cdb_ext_tag)) begin
                    tag1_q[i] <= '0;
                    addr_q[i] <= cdb_ext_val + imm_q[i];
                end else if (bus_hit(tag1_q[i], cdb_mem_tag)) begin
                    tag1_q[i] <= '0;
                    addr_q[i] <= cdb_mem_val + imm_q[i];
                end
                if (bus_hit(tag2_q[i], cdb_ext_tag)) begin
                    tag2_q[i] <= '0;
                    val2_q[i] <= cdb_ext_val;
                end else if (bus_hit(tag2_q[i], cdb_mem_tag)) begin
                    tag2_q[i] <= '0;
                    val2_q[i] <= cdb_mem_val;
                end
            end
        end
        if (disp_fire) begin
            op_q[tail]   <= disp_op;
            rob_q[tail]  <= disp_rob_tag;
            rd_q[tail]   <= disp_rd;
            tag1_q[tail] <= d_tag1;
            tag2_q[tail] <= d_tag2;
            val2_q[tail] <= d_val2;
            imm_q[tail]  <= disp_imm;
            addr_q[tail] <= d_val1 + disp_imm; // recomputed later if the base is still pending.
        end
        if (issue_ok) begin
            mem_op   <= op_q[head];
            mem_addr <= addr_q[head];
            mem_data <= val2_q[head];
            mem_tag  <= rob_q[head];
            mem_rd   <= rd_q[head];
        end
    end

endmodule

`default_nettype wire

// ==== ldst_mem_unit.sv ====
// Data memory engine: answers each buffer request with one access and drives the result pulses.
`timescale 1ns/1ps
`default_nettype none

module ldst_mem_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req,
    input  lsq_pkg::ldst_op_e mem_op,
    input  lsq_pkg::word_t    mem_addr,
    input  lsq_pkg::word_t    mem_data,
    input  lsq_pkg::tag_t     mem_tag,
    input  lsq_pkg::tag_t     mem_rd,
    output logic              mem_ack,
    output lsq_pkg::tag_t     cdb_mem_tag,
    output lsq_pkg::word_t    cdb_mem_val,
    output lsq_pkg::tag_t     res_rd,
    output logic              store_done,
    output lsq_pkg::tag_t     store_tag
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACKED,
        ST_WAIT_REL
    } state_t;

    state_t state;
    logic   req_q; // registered view of the request line.
    logic   access;

    logic [lsq_pkg::MEM_AW-1:0] word_idx;
    lsq_pkg::word_t             mem_array [lsq_pkg::MEM_WORDS];

    assign word_idx = mem_addr[lsq_pkg::MEM_AW+1:2];
    assign access   = (state == ST_IDLE) && req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            req_q       <= 1'b0;
            mem_ack     <= 1'b0;
            cdb_mem_tag <= '0;
            store_done  <= 1'b0;
        end else begin
            req_q       <= mem_req;
            cdb_mem_tag <= '0;
            store_done  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_q) begin
                        mem_ack <= 1'b1;
                        state   <= ST_ACKED;
                        if (mem_op == lsq_pkg::LDST_LW) begin
                            cdb_mem_tag <= mem_tag;
                        end else begin
                            store_done <= 1'b1;
                        end
                    end
                end
                ST_ACKED: state <= ST_WAIT_REL; // the buffer drops req on this edge.
                ST_WAIT_REL: begin
                    if (!mem_req) begin
                        mem_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the array and the result payload carry no reset.
    always_ff @(posedge clk) begin
        if (access) begin
            if (mem_op == lsq_pkg::LDST_SW) begin
                mem_array[word_idx] <= mem_data;
            end else begin
                cdb_mem_val <= mem_array[word_idx];
            end
            res_rd    <= mem_rd;
            store_tag <= mem_tag;
        end
    end

endmodule

`default_nettype wire

// ==== lsq_top.sv ====
// Load/store stage top: connects the entry buffer to the memory unit and loops the result bus back.
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid,
    input  lsq_pkg::ldst_op_e disp_op,
    input  lsq_pkg::tag_t     disp_rob_tag,
    input  lsq_pkg::tag_t     disp_rd,
    input  lsq_pkg::tag_t     disp_src1_tag,
    input  lsq_pkg::tag_t     disp_src2_tag,
    input  lsq_pkg::word_t    disp_src1_val,
    input  lsq_pkg::word_t    disp_src2_val,
    input  lsq_pkg::word_t    disp_imm,
    input  lsq_pkg::tag_t     cdb_ext_tag,
    input  lsq_pkg::word_t    cdb_ext_val,
    input  lsq_pkg::tag_t     rob_head,
    input  logic              flush,
    output logic              disp_ready,
    output lsq_pkg::tag_t     cdb_mem_tag,
    output lsq_pkg::word_t    cdb_mem_val,
    output lsq_pkg::tag_t     res_rd,
    output logic              store_done,
    output lsq_pkg::tag_t     store_tag
);

    logic              mem_req;
    logic              mem_ack;
    lsq_pkg::ldst_op_e mem_op;
    lsq_pkg::word_t    mem_addr;
    lsq_pkg::word_t    mem_data;
    lsq_pkg::tag_t     mem_tag;
    lsq_pkg::tag_t     mem_rd;

    ldst_buffer u_buffer (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_rob_tag  (disp_rob_tag),
        .disp_rd       (disp_rd),
        .disp_src1_tag (disp_src1_tag),
        .disp_src2_tag (disp_src2_tag),
        .disp_src1_val (disp_src1_val),
        .disp_src2_val (disp_src2_val),
        .disp_imm      (disp_imm),
        .cdb_ext_tag   (cdb_ext_tag),
        .cdb_mem_tag   (cdb_mem_tag), // load results feed waiting entries.
        .cdb_ext_val   (cdb_ext_val),
        .cdb_mem_val   (cdb_mem_val),
        .rob_head      (rob_head),
        .flush         (flush),
        .mem_ack       (mem_ack),
        .disp_ready    (disp_ready),
        .mem_req       (mem_req),
        .mem_op        (mem_op),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .mem_tag       (mem_tag),
        .mem_rd        (mem_rd)
    );

    ldst_mem_unit u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_tag     (mem_tag),
        .mem_rd      (mem_rd),
        .mem_ack     (mem_ack),
        .cdb_mem_tag (cdb_mem_tag),
        .cdb_mem_val (cdb_mem_val),
        .res_rd      (res_rd),
        .store_done  (store_done),
        .store_tag   (store_tag)
    );

endmodule

`default_nettype wire

// ==== lsq_props.sv ====
// Handshake and dispatch assertions for the load/store buffer, attached to ldst_buffer by bind.
`timescale 1ns/1ps
`default_nettype none

module lsq_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          disp_valid,
    input logic                          disp_ready,
    input logic                          flush,
    input logic [lsq_pkg::LSQ_IDX_W-1:0] tail,
    input logic                          mem_req,
    input logic                          mem_ack,
    input lsq_pkg::ldst_op_e             mem_op,
    input lsq_pkg::word_t                mem_addr,
    input lsq_pkg::word_t                mem_data,
    input lsq_pkg::tag_t                 mem_tag,
    input lsq_pkg::tag_t                 mem_rd
);

    // a raised request keeps its payload until the unit answers.
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req && $stable(mem_op) && $stable(mem_addr)
            && $stable(mem_data) && $stable(mem_tag) && $stable(mem_rd))
        else $error("mem_req or its payload changed before mem_ack");

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_ack) |-> mem_req)
        else $error("mem_ack rose without mem_req");

    // a full buffer must not move its tail.
    a_no_accept_full: assert property (@(posedge clk) disable iff (rst)
        disp_valid && !disp_ready && !flush |=> $stable(tail))
        else $error("dispatch accepted while disp_ready was low");

    a_no_req_during_ack: assert property (@(posedge clk) disable iff (rst)
        mem_ack |=> !$rose(mem_req))
        else $error("mem_req rose while mem_ack was still high");

endmodule

bind ldst_buffer lsq_props u_props (
    .clk        (clk),
    .rst        (rst),
    .disp_valid (disp_valid),
    .disp_ready (disp_ready),
    .flush      (flush),
    .tail       (tail),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_op     (mem_op),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .mem_tag    (mem_tag),
    .mem_rd     (mem_rd)
);

`default_nettype wire

// ==== tb_lsq.sv ====
// Testbench for lsq_top: replays lsq_vectors.txt from the project root and checks each result.
`timescale 1ns/1ps
`default_nettype none

module tb_lsq;

    localparam int CYCLES_PER_LINE = 40;
    localparam int WAIT_LIMIT      = 100; // per expectation or held dispatch.

    logic              clk;
    logic              rst;
    logic              disp_valid;
    lsq_pkg::ldst_op_e disp_op;
    lsq_pkg::tag_t     disp_rob_tag;
    lsq_pkg::tag_t     disp_rd;
    lsq_pkg::tag_t     disp_src1_tag;
    lsq_pkg::tag_t     disp_src2_tag;
    lsq_pkg::word_t    disp_src1_val;
    lsq_pkg::word_t    disp_src2_val;
    lsq_pkg::word_t    disp_imm;
    lsq_pkg::tag_t     cdb_ext_tag;
    lsq_pkg::word_t    cdb_ext_val;
    lsq_pkg::tag_t     rob_head;
    logic              flush;
    logic              disp_ready;
    lsq_pkg::tag_t     cdb_mem_tag;
    lsq_pkg::word_t    cdb_mem_val;
    lsq_pkg::tag_t     res_rd;
    logic              store_done;
    lsq_pkg::tag_t     store_tag;

    // completions seen on the outputs, oldest first.
    lsq_pkg::tag_t  load_tag_q  [$];
    lsq_pkg::tag_t  load_rd_q   [$];
    lsq_pkg::word_t load_val_q  [$];
    lsq_pkg::tag_t  store_tag_q [$];

    int accept_count = 0;
    int held_count   = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    lsq_top u_lsq_top (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_rob_tag  (disp_rob_tag),
        .disp_rd       (disp_rd),
        .disp_src1_tag (disp_src1_tag),
        .disp_src2_tag (disp_src2_tag),
        .disp_src1_val (disp_src1_val),
        .disp_src2_val (disp_src2_val),
        .disp_imm      (disp_imm),
        .cdb_ext_tag   (cdb_ext_tag),
        .cdb_ext_val   (cdb_ext_val),
        .rob_head      (rob_head),
        .flush         (flush),
        .disp_ready    (disp_ready),
        .cdb_mem_tag   (cdb_mem_tag),
        .cdb_mem_val   (cdb_mem_val),
        .res_rd        (res_rd),
        .store_done    (store_done),
        .store_tag     (store_tag)
    );

    always #2 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input lsq_pkg::word_t got,
                              input lsq_pkg::word_t exp);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input lsq_pkg::tag_t got,
                             input lsq_pkg::tag_t exp);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // every step ends just after a rising edge, where inputs are driven.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            report_error($sformatf("timeout: the run went past %0d cycles", cycle_limit));
        end
    end

    // mid-cycle sampling sees each one-cycle pulse exactly once.
    always @(negedge clk) begin
        if (!rst) begin
            if (cdb_mem_tag != '0) begin
                load_tag_q.push_back(cdb_mem_tag);
                load_rd_q.push_back(res_rd);
                load_val_q.push_back(cdb_mem_val);
            end
            if (store_done) begin
                store_tag_q.push_back(store_tag);
            end
            if (disp_valid && disp_ready && !flush) begin
                accept_count++; // taken on the coming rising edge.
            end
        end
    end

    task automatic await_dispatch();
        int waited;
        waited = 0;
        while (accept_count == held_count) begin
            if (waited >= WAIT_LIMIT) begin
                report_error("a dispatch was never accepted");
            end
            next_cycle();
            waited++;
        end
        if (accept_count != held_count + 1) begin
            report_error("one dispatch was accepted more than once");
        end
        disp_valid = 1'b0;
    endtask

    task automatic await_result(input logic is_load);
        int waited;
        waited = 0;
        while ((is_load ? load_tag_q.size() : store_tag_q.size()) == 0) begin
            if (waited >= WAIT_LIMIT) begin
                report_error(is_load ? "no load result arrived in time"
                                     : "no store completion arrived in time");
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic expect_nothing();
        if (load_tag_q.size() != 0) begin
            report_error($sformatf("unexpected load result with tag 0x%02h", load_tag_q[0]));
        end
        if (store_tag_q.size() != 0) begin
            report_error($sformatf("unexpected store completion with tag 0x%02h",
                                   store_tag_q[0]));
        end
    endtask

    task automatic run_command(input int fd, input string cmd);
        logic           op_v;
        lsq_pkg::tag_t  t_a;
        lsq_pkg::tag_t  t_b;
        lsq_pkg::tag_t  t_c;
        lsq_pkg::tag_t  t_d;
        lsq_pkg::word_t w_a;
        lsq_pkg::word_t w_b;
        lsq_pkg::word_t w_c;
        int             n;
        int             c;
        if (cmd.getc(0) == "#") begin
            c = $fgetc(fd);
            while (c != 10 && c != -1) begin
                c = $fgetc(fd);
            end
        end else if (cmd == "D" || cmd == "DH") begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h", op_v, t_a, t_b, t_c, w_a, t_d, w_b, w_c);
            if (n != 8) begin
                report_error("malformed dispatch line in the vector file");
            end
            disp_op       = lsq_pkg::ldst_op_e'(op_v);
            disp_rob_tag  = t_a;
            disp_rd       = t_b;
            disp_src1_tag = t_c;
            disp_src1_val = w_a;
            disp_src2_tag = t_d;
            disp_src2_val = w_b;
            disp_imm      = w_c;
            disp_valid    = 1'b1;
            held_count    = accept_count;
            if (cmd == "D") begin
                await_dispatch();
            end
        end else if (cmd == "DW") begin
            await_dispatch();
        end else if (cmd == "B") begin
            n = $fscanf(fd, "%h %h", t_a, w_a);
            cdb_ext_tag = t_a;
            cdb_ext_val = w_a;
            next_cycle();
            cdb_ext_tag = '0;
        end else if (cmd == "H") begin
            n = $fscanf(fd, "%h", t_a);
            rob_head = t_a;
            next_cycle();
        end else if (cmd == "F") begin
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
        end else if (cmd == "W") begin
            n = $fscanf(fd, "%d", c);
            repeat (c) next_cycle();
        end else if (cmd == "R") begin
            n = $fscanf(fd, "%h", op_v);
            check_bit("disp_ready", disp_ready, op_v);
        end else if (cmd == "EL") begin
            n = $fscanf(fd, "%h %h %h", t_a, t_b, w_a);
            await_result(1'b1);
            check_tag("cdb_mem_tag", load_tag_q.pop_front(), t_a);
            check_tag("res_rd", load_rd_q.pop_front(), t_b);
            check_word("cdb_mem_val", load_val_q.pop_front(), w_a);
        end else if (cmd == "ES") begin
            n = $fscanf(fd, "%h", t_a);
            await_result(1'b0);
            check_tag("store_tag", store_tag_q.pop_front(), t_a);
        end else if (cmd == "EN") begin
            expect_nothing();
        end else begin
            report_error($sformatf("unknown command %s in the vector file", cmd));
        end
    endtask

    initial begin
        int    fd;
        int    r;
        int    c;
        int    lines;
        string cmd;
        clk           = 1'b0;
        rst           = 1'b1;
        disp_valid    = 1'b0;
        disp_op       = lsq_pkg::LDST_LW;
        disp_rob_tag  = '0;
        disp_rd       = '0;
        disp_src1_tag = '0;
        disp_src2_tag = '0;
        disp_src1_val = '0;
        disp_src2_val = '0;
        disp_imm      = '0;
        cdb_ext_tag   = '0;
        cdb_ext_val   = '0;
        rob_head      = '0;
        flush         = 1'b0;
        fd = $fopen("lsq_vectors.txt", "r");
        if (fd == 0) begin
            report_error("cannot open lsq_vectors.txt");
        end
        lines = 0;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == 10) begin
                lines++;
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = (lines + 1) * CYCLES_PER_LINE;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        fd = $fopen("lsq_vectors.txt", "r");
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", cmd);
            if (r == 1) begin
                run_command(fd, cmd);
            end
        end
        $fclose(fd);
        repeat (8) next_cycle();
        expect_nothing();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsq_vectors.txt ====
# D op rob rd s1tag s1val s2tag s2val imm (hex, op 0 load 1 store), DH holds it, DW awaits it
# B tag val, H tag, F, W cycles (decimal), R ready, EL tag rd val, ES tag, EN nothing pending
# store then load
H 01
D 1 01 00 00 00000100 00 cafef00d 00000010
ES 01
H 02
D 1 02 00 00 00000200 00 0badc0de 00000004
ES 02
D 0 03 04 00 00000100 00 00000000 00000010
EL 03 04 cafef00d
# base delivered by an external broadcast
D 0 06 07 0a 00000000 00 00000000 00000004
W 8
EN
B 0a 00000200
EL 06 07 0badc0de
# store waits for the ROB head and the younger load waits behind it
D 1 08 00 00 00000300 00 11112222 00000000
D 0 09 0a 00 00000110 00 00000000 00000000
W 8
EN
H 08
ES 08
EL 09 0a cafef00d
D 0 0b 0c 00 00000300 00 00000000 00000000
EL 0b 0c 11112222
# fill every entry behind an unresolved head
W 4
D 0 11 01 1a 00000000 00 00000000 00000010
D 0 12 02 00 00000200 00 00000000 00000004
D 0 13 03 00 00000300 00 00000000 00000000
D 0 14 04 00 00000100 00 00000000 00000010
D 0 15 05 00 000002f0 00 00000000 00000010
D 0 16 06 00 00000204 00 00000000 00000000
D 0 17 07 00 00000010 00 00000000 00000100
D 0 18 08 00 00000400 00 00000000 fffffd10
R 0
DH 0 19 09 00 00000200 00 00000000 00000004
W 4
R 0
EN
B 1a 00000100
DW
EL 11 01 cafef00d
EL 12 02 0badc0de
EL 13 03 11112222
EL 14 04 cafef00d
EL 15 05 11112222
EL 16 06 0badc0de
EL 17 07 cafef00d
EL 18 08 cafef00d
EL 19 09 0badc0de
R 1
# load result forwarded into a waiting store
H 1c
D 0 1b 0b 00 00000200 00 00000000 00000004
D 1 1c 00 00 00000500 1b 00000000 00000000
EL 1b 0b 0badc0de
ES 1c
D 0 1d 0d 00 00000500 00 00000000 00000000
EL 1d 0d 0badc0de
# flush drops unresolved entries
W 4
D 0 01 01 1e 00000000 00 00000000 00000010
D 1 02 00 00 00000600 1f 00000000 00000000
F
H 02
B 1e 00000100
B 1f 55555555
W 12
EN
H 04
D 1 04 00 00 00000600 00 a5a5a5a5 00000000
ES 04
D 0 05 06 00 00000600 00 00000000 00000000
EL 05 06 a5a5a5a5
EN

// ==== project.f ====
lsq_pkg.sv
ldst_buffer.sv
ldst_mem_unit.sv
lsq_top.sv
lsq_props.sv
tb_lsq.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_lsq
FILELIST  = project.f
PASS_MSG  = Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output.
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
